// ==== afifo_pkg.sv ====
package afifo_pkg;

  // width of one data word as it enters on wr_data and leaves on rd_data
  localparam int DATA_WIDTH = 8;

  // number of words the RAM holds
  localparam int FIFO_DEPTH = 16;

  // RAM address width
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // pointers carry one extra bit so that full and empty differ by the wrap bit
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // afull is raised once the write side sees this many words or more
  localparam int FIFO_AFULL = FIFO_DEPTH - 1;

  // aempty is raised once the read side sees this many words or fewer
  localparam int FIFO_AEMPTY = 1;

endpackage

// ==== afifo_gray_sync.sv ====
`timescale 1ns/100ps

module afifo_gray_sync (
  input  logic                           dst_clk  ,
  input  logic                           dst_rst_n,
  input  logic [afifo_pkg::PTR_WIDTH-1:0] gray_in  ,
  output logic [afifo_pkg::PTR_WIDTH-1:0] bin_out
);

  logic [afifo_pkg::PTR_WIDTH-1:0] sync_q1; // may go metastable
  logic [afifo_pkg::PTR_WIDTH-1:0] sync_q2;

  // only one bit of gray_in moves per source edge, so a late sample is off by one step at most
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // each binary bit is the xor of all gray bits at or above it
  always_comb begin
    bin_out[afifo_pkg::PTR_WIDTH-1] = sync_q2[afifo_pkg::PTR_WIDTH-1];
    for (int i = afifo_pkg::PTR_WIDTH - 2; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ sync_q2[i];
    end
  end

endmodule

// ==== afifo_wr_ctrl.sv ====
`timescale 1ns/100ps

module afifo_wr_ctrl (
  input  logic                            wr_clk     ,
  input  logic                            wr_rst_n   ,
  input  logic                            wr_en      ,
  input  logic [afifo_pkg::PTR_WIDTH-1:0]  rd_ptr_wsyn,
  output logic                            wr_take    ,
  output logic [afifo_pkg::ADDR_WIDTH-1:0] wr_addr    ,
  output logic [afifo_pkg::PTR_WIDTH-1:0]  wr_gray    ,
  output logic                            full       ,
  output logic                            afull
);

  logic [afifo_pkg::PTR_WIDTH-1:0] wr_ptr;
  logic [afifo_pkg::PTR_WIDTH-1:0] wr_ptr_nxt;
  logic [afifo_pkg::PTR_WIDTH-1:0] wr_gray_nxt;
  logic [afifo_pkg::PTR_WIDTH-1:0] wr_used_nxt; // occupancy as seen after this edge
  logic                            full_nxt;
  logic                            afull_nxt;

  // a write enable raised while full is ignored
  assign wr_take = wr_en && !full;

  assign wr_addr = wr_ptr[afifo_pkg::ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_take) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  // the gray copy moves on the same edge as the binary pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= wr_gray_nxt;
    end
  end

  // the synchronized read pointer lags, so this count is never below the true one
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_wsyn;

  always_comb begin
    full_nxt  = (wr_used_nxt == afifo_pkg::FIFO_DEPTH);
    afull_nxt = (wr_used_nxt >= afifo_pkg::FIFO_AFULL);
  end

  // full rises on the edge that takes the last free slot
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

// ==== afifo_rd_ctrl.sv ====
`timescale 1ns/100ps

module afifo_rd_ctrl (
  input  logic                            rd_clk     ,
  input  logic                            rd_rst_n   ,
  input  logic                            rd_en      ,
  input  logic [afifo_pkg::PTR_WIDTH-1:0]  wr_ptr_rsyn,
  output logic                            rd_take    ,
  output logic [afifo_pkg::ADDR_WIDTH-1:0] rd_addr    ,
  output logic [afifo_pkg::PTR_WIDTH-1:0]  rd_gray    ,
  output logic                            empty      ,
  output logic                            aempty
);

  logic [afifo_pkg::PTR_WIDTH-1:0] rd_ptr;
  logic [afifo_pkg::PTR_WIDTH-1:0] rd_ptr_nxt;
  logic [afifo_pkg::PTR_WIDTH-1:0] rd_gray_nxt;
  logic [afifo_pkg::PTR_WIDTH-1:0] rd_used_nxt; // words left once this edge is done
  logic                            empty_nxt;
  logic                            aempty_nxt;

  // a read enable raised while empty is ignored
  assign rd_take = rd_en && !empty;

  assign rd_addr = rd_ptr[afifo_pkg::ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_take) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= rd_gray_nxt;
    end
  end

  // the synchronized write pointer lags, so this count is never above the true one
  assign rd_used_nxt = wr_ptr_rsyn - rd_ptr_nxt;

  always_comb begin
    empty_nxt  = (rd_used_nxt == '0);
    aempty_nxt = (rd_used_nxt <= afifo_pkg::FIFO_AEMPTY);
  end

  // empty rises on the edge that takes the last word
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

// ==== afifo_dpram.sv ====
`timescale 1ns/100ps

module afifo_dpram (
  input  logic                            wr_clk  ,
  input  logic                            wr_take ,
  input  logic [afifo_pkg::ADDR_WIDTH-1:0] wr_addr ,
  input  logic [afifo_pkg::DATA_WIDTH-1:0] wr_data ,
  input  logic                            rd_clk  ,
  input  logic                            rd_rst_n,
  input  logic                            rd_take ,
  input  logic [afifo_pkg::ADDR_WIDTH-1:0] rd_addr ,
  output logic [afifo_pkg::DATA_WIDTH-1:0] rd_data
);

  logic [afifo_pkg::DATA_WIDTH-1:0] mem [afifo_pkg::FIFO_DEPTH];

  // write port, the controller only raises wr_take when a slot is free
  always_ff @(posedge wr_clk) begin
    if (wr_take) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port
  // the word stays on rd_data until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_take) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== async_fifo.sv ====
`timescale 1ns/100ps

module async_fifo (
  // write clock domain
  input  logic                            wr_clk  ,
  input  logic                            wr_rst_n,
  input  logic                            wr_en   ,
  input  logic [afifo_pkg::DATA_WIDTH-1:0] wr_data ,
  output logic                            full    ,
  output logic                            afull   ,
  // read clock domain
  input  logic                            rd_clk  ,
  input  logic                            rd_rst_n,
  input  logic                            rd_en   ,
  output logic [afifo_pkg::DATA_WIDTH-1:0] rd_data ,
  output logic                            empty   ,
  output logic                            aempty
);

  // write side nets
  logic                            wr_take;
  logic [afifo_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [afifo_pkg::PTR_WIDTH-1:0]  wr_gray;
  logic [afifo_pkg::PTR_WIDTH-1:0]  rd_ptr_wsyn; // read pointer seen in wr_clk

  // read side nets
  logic                            rd_take;
  logic [afifo_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [afifo_pkg::PTR_WIDTH-1:0]  rd_gray;
  logic [afifo_pkg::PTR_WIDTH-1:0]  wr_ptr_rsyn; // write pointer seen in rd_clk

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk     (wr_clk     ),
    .wr_rst_n   (wr_rst_n   ),
    .wr_en      (wr_en      ),
    .rd_ptr_wsyn(rd_ptr_wsyn),
    .wr_take    (wr_take    ),
    .wr_addr    (wr_addr    ),
    .wr_gray    (wr_gray    ),
    .full       (full       ),
    .afull      (afull      )
  );

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk     (rd_clk     ),
    .rd_rst_n   (rd_rst_n   ),
    .rd_en      (rd_en      ),
    .wr_ptr_rsyn(wr_ptr_rsyn),
    .rd_take    (rd_take    ),
    .rd_addr    (rd_addr    ),
    .rd_gray    (rd_gray    ),
    .empty      (empty      ),
    .aempty     (aempty     )
  );

  // the write pointer crossing into rd_clk drives empty and aempty
  afifo_gray_sync u_sync_w2r (
    .dst_clk  (rd_clk     ),
    .dst_rst_n(rd_rst_n   ),
    .gray_in  (wr_gray    ),
    .bin_out  (wr_ptr_rsyn)
  );

  // the read pointer crossing into wr_clk drives full and afull
  afifo_gray_sync u_sync_r2w (
    .dst_clk  (wr_clk     ),
    .dst_rst_n(wr_rst_n   ),
    .gray_in  (rd_gray    ),
    .bin_out  (rd_ptr_wsyn)
  );

  afifo_dpram u_ram (
    .wr_clk  (wr_clk  ),
    .wr_take (wr_take ),
    .wr_addr (wr_addr ),
    .wr_data (wr_data ),
    .rd_clk  (rd_clk  ),
    .rd_rst_n(rd_rst_n),
    .rd_take (rd_take ),
    .rd_addr (rd_addr ),
    .rd_data (rd_data )
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clk
);

  // first rising edge comes half a period after time zero
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk = ~clk;
    end
  end

endmodule

// ==== tb_async_fifo.sv ====
`timescale 1ns/100ps

module tb_async_fifo;

  localparam int DW             = afifo_pkg::DATA_WIDTH;
  localparam int RAND_LEN       = 2048;
  localparam int RANDOM_WRITES  = 300;
  localparam int BURST_TRIES    = afifo_pkg::FIFO_DEPTH + 4; // four tries past full or empty
  localparam int SETTLE_CYCLES  = 10;
  localparam int TIMEOUT_CYCLES = 4000; // four phases of up to about 600 rd_clk cycles each

  logic          rd_clk;
  logic          wr_clk;
  logic          rd_rst_n;
  logic          wr_rst_n;
  logic          wr_en;
  logic [DW-1:0] wr_data;
  logic          full;
  logic          afull;
  logic          rd_en;
  logic [DW-1:0] rd_data;
  logic          empty;
  logic          aempty;

  // reference model, words stay in the queue and pop_cnt marks the head
  logic [DW-1:0] model_q [$];
  int            push_cnt;
  int            pop_cnt;
  logic [DW-1:0] rd_expect;
  int            level;
  logic          exp_full;
  logic          exp_afull;
  logic          exp_empty;
  logic          exp_aempty;

  // phase markers that enable the flag checks
  logic          chk_reset;
  logic          in_fill;
  logic          in_drain;
  logic          settled;
  logic          wr_done;

  int            seed;
  int            cycle_cnt = 0;
  bit            wr_en_pat  [RAND_LEN];
  logic [DW-1:0] wr_dat_pat [RAND_LEN];
  bit            rd_en_pat  [RAND_LEN];

  tb_clk_gen #(.PERIOD_NS(20.0)) u_rd_clk_gen (.clk(rd_clk));
  tb_clk_gen #(.PERIOD_NS(14.0)) u_wr_clk_gen (.clk(wr_clk)); // drifts against rd_clk

  async_fifo async_fifo_i (
    .wr_clk  (wr_clk  ),
    .wr_rst_n(wr_rst_n),
    .wr_en   (wr_en   ),
    .wr_data (wr_data ),
    .full    (full    ),
    .afull   (afull   ),
    .rd_clk  (rd_clk  ),
    .rd_rst_n(rd_rst_n),
    .rd_en   (rd_en   ),
    .rd_data (rd_data ),
    .empty   (empty   ),
    .aempty  (aempty  )
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // a write is taken on each wr_clk edge with wr_en high and full low
  always @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      model_q.delete();
      push_cnt <= 0;
    end else if (wr_en && !full) begin
      model_q.push_back(wr_data);
      push_cnt <= push_cnt + 1;
    end
  end

  // a read is taken on each rd_clk edge with rd_en high and empty low
  always @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      pop_cnt   <= 0;
      rd_expect <= '0;
    end else if (rd_en && !empty) begin
      if (pop_cnt < model_q.size()) begin
        rd_expect <= model_q[pop_cnt];
        pop_cnt   <= pop_cnt + 1;
      end else begin
        stop_on_error("a read was taken while the model held no unread word");
      end
    end
  end

  assign level      = push_cnt - pop_cnt;
  assign exp_full   = (level == afifo_pkg::FIFO_DEPTH);
  assign exp_afull  = (level >= afifo_pkg::FIFO_AFULL);
  assign exp_empty  = (level == 0);
  assign exp_aempty = (level <= afifo_pkg::FIFO_AEMPTY);

  always @(posedge rd_clk) begin
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout, the run took more than %0d rd_clk cycles",
                              TIMEOUT_CYCLES));
    end
    cycle_cnt <= cycle_cnt + 1;
  end

  // flags while reset is held and just after it
  assert property (@(posedge wr_clk) chk_reset |-> !full)
    else stop_on_error($sformatf("ERR full exp %h got %h", 1'b0, $sampled(full)));
  assert property (@(posedge wr_clk) chk_reset |-> !afull)
    else stop_on_error($sformatf("ERR afull exp %h got %h", 1'b0, $sampled(afull)));
  assert property (@(posedge rd_clk) chk_reset |-> empty)
    else stop_on_error($sformatf("ERR empty exp %h got %h", 1'b1, $sampled(empty)));
  assert property (@(posedge rd_clk) chk_reset |-> aempty)
    else stop_on_error($sformatf("ERR aempty exp %h got %h", 1'b1, $sampled(aempty)));

  // rd_data holds the last word read, so reads on empty leave it alone
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n) rd_data == rd_expect)
    else stop_on_error($sformatf("ERR rd_data exp %h got %h",
                                 $sampled(rd_expect), $sampled(rd_data)));

  // with no reads in flight the write side flags follow the model exactly
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
                   (in_fill || settled) |-> full == exp_full)
    else stop_on_error($sformatf("ERR full exp %h got %h",
                                 $sampled(exp_full), $sampled(full)));
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
                   (in_fill || settled) |-> afull == exp_afull)
    else stop_on_error($sformatf("ERR afull exp %h got %h",
                                 $sampled(exp_afull), $sampled(afull)));

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                   (in_drain || settled) |-> empty == exp_empty)
    else stop_on_error($sformatf("ERR empty exp %h got %h",
                                 $sampled(exp_empty), $sampled(empty)));
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                   (in_drain || settled) |-> aempty == exp_aempty)
    else stop_on_error($sformatf("ERR aempty exp %h got %h",
                                 $sampled(exp_aempty), $sampled(aempty)));

  task automatic make_patterns();
    for (int i = 0; i < RAND_LEN; i++) begin
      wr_en_pat[i]  = (($random(seed) & 32'h7fff_ffff) % 100) < 60;
      wr_dat_pat[i] = DW'($random(seed));
      rd_en_pat[i]  = (($random(seed) & 32'h7fff_ffff) % 100) < 50;
    end
  endtask

  task automatic write_burst(input int tries, input int base);
    for (int i = 0; i < tries; i++) begin
      @(negedge wr_clk);
      wr_en   = 1'b1;
      wr_data = DW'(base + i);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_burst(input int tries);
    for (int i = 0; i < tries; i++) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  // both pointers have crossed once the enables have been low this long
  task automatic settle_and_check();
    repeat (SETTLE_CYCLES) @(negedge rd_clk);
    settled = 1'b1;
    @(negedge rd_clk);
    settled = 1'b0;
  endtask

  task automatic random_traffic();
    int wr_idx;
    int rd_idx;
    int target;
    wr_idx  = 0;
    rd_idx  = 0;
    target  = push_cnt + RANDOM_WRITES;
    wr_done = 1'b0;
    fork
      begin
        @(negedge wr_clk);
        while (push_cnt < target) begin
          wr_en   = wr_en_pat[wr_idx % RAND_LEN];
          wr_data = wr_dat_pat[wr_idx % RAND_LEN];
          wr_idx++;
          @(negedge wr_clk);
        end
        wr_en   = 1'b0;
        wr_done = 1'b1;
      end
      begin
        while (!wr_done) begin
          @(negedge rd_clk);
          rd_en = rd_en_pat[rd_idx % RAND_LEN];
          rd_idx++;
        end
        rd_en = 1'b0;
      end
    join
  endtask

  initial begin
    seed      = 65;
    rd_rst_n  = 1'b0;
    wr_rst_n  = 1'b0;
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    chk_reset = 1'b0;
    in_fill   = 1'b0;
    in_drain  = 1'b0;
    settled   = 1'b0;
    wr_done   = 1'b0;
    make_patterns();

    // reset, the flag checks start once the first edge has cleared the flops
    @(negedge rd_clk);
    chk_reset = 1'b1;
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    wr_rst_n = 1'b1;
    repeat (4) @(negedge rd_clk);
    chk_reset = 1'b0;
    settle_and_check();

    // fill, the last four tries hit a full FIFO
    @(negedge wr_clk);
    in_fill = 1'b1;
    write_burst(BURST_TRIES, 8'h40);
    in_fill = 1'b0;
    settle_and_check();

    // drain, the last four tries hit an empty FIFO
    @(negedge rd_clk);
    in_drain = 1'b1;
    read_burst(BURST_TRIES);
    in_drain = 1'b0;
    settle_and_check();

    random_traffic();
    settle_and_check();
    read_burst(BURST_TRIES);
    settle_and_check();

    if (push_cnt == pop_cnt && pop_cnt > 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with %0d words written and %0d read",
                              push_cnt, pop_cnt));
    end
  end

endmodule

// ==== filelist.f ====
afifo_pkg.sv
afifo_gray_sync.sv
afifo_wr_ctrl.sv
afifo_rd_ctrl.sv
afifo_dpram.sv
async_fifo.sv
tb_clk_gen.sv
tb_async_fifo.sv
